//--- Bender.yml
package:
  name: riscv_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/core_pkg.sv
      - logic/fetch_stage.sv
      - logic/reg_file.sv
      - logic/decode_stage.sv
      - logic/execute_stage.sv
      - logic/retire_stage.sv
      - logic/riscv_core.sv
  - target: simulation
    include_dirs:
      - logic
      - dv
    files:
      - dv/core_tb.sv

//--- dv/core_ref_model.svh
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_step();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
        lfsr = lfsr ^ 16'hB400;
    end
    return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

function automatic logic is_legal(input logic [31:0] w);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = w[31:25];
    f3 = w[14:12];
    case (w[6:0])
        `OPC_OP: begin
            return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end
        `OPC_OP_IMM: begin
            // Only the shifts constrain the upper immediate bits
            return (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
        end
        `OPC_BRANCH: begin
            return f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd5;
        end
        default: begin
            return 1'b0;
        end
    endcase
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

task automatic push_expected(input logic [31:0] pc, input logic we,
                             input logic [4:0] rd, input logic [31:0] data);
    exp_pc_q.push_back(pc);
    exp_we_q.push_back(we);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    ref_count = ref_count + 1;
endtask

// ALU ops on x0..x7, forward branches and a few illegal words
task automatic gen_program();
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] f3;
    logic [31:0] imm;
    logic [6:0]  f7;
    lfsr = 16'd5;
    for (int i = 0; i < PROG_WORDS; i++) begin
        kind = rand_bits(4);
        rd   = rand_bits(3);
        rs1  = rand_bits(3);
        rs2  = rand_bits(3);
        f3   = rand_bits(3);
        f7   = 7'h00;
        if (kind == 15) begin
            // Store opcode or an M-extension funct7
            if (lfsr_step()) begin
                imm = rand_bits(25);
                prog_mem[i] = {imm[24:0], 7'b0100011};
            end else begin
                prog_mem[i] = {7'h01, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP};
            end
        end else if (kind >= 12) begin
            // BEQ, BNE, BLT or BGE jumping 2 to 6 words ahead
            f3[1] = 1'b0;
            imm   = (rand_bits(3) % 5 + 2) * 4;
            prog_mem[i] = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0],
                           imm[4:1], imm[11], `OPC_BRANCH};
        end else if (lfsr_step()) begin
            if ((f3 == 0 || f3 == 5) && lfsr_step()) begin
                f7 = 7'h20;
            end
            prog_mem[i] = {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP};
        end else begin
            imm = rand_bits(12);
            if (f3 == 1 || f3 == 5) begin
                imm[11:5] = (f3 == 5 && lfsr_step()) ? 7'h20 : 7'h00;
            end
            prog_mem[i] = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP_IMM};
        end
    end
endtask

// In-order execution up to the end of the program
task automatic run_model();
    logic [`XLEN-1:0] x [0:`NUM_REGS-1];
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] w;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] res;
    logic [`XLEN-1:0] off;
    logic             alt;
    logic             taken;
    for (int r = 0; r < `NUM_REGS; r++) begin
        x[r] = '0;
    end
    pc        = `RESET_PC;
    ref_count = 0;
    while (pc < PROG_BYTES) begin
        w = prog_mem[pc[IDX_W+1:2]];
        a = x[w[19:15]];
        b = x[w[24:20]];
        if (!is_legal(w)) begin
            pc = pc + `PC_STEP;
        end else if (w[6:0] == `OPC_BRANCH) begin
            off = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            case (w[14:12])
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = ($signed(a) < $signed(b));
                default: taken = ($signed(a) >= $signed(b));
            endcase
            push_expected(pc, 1'b0, 5'd0, 32'd0);
            pc = taken ? pc + off : pc + `PC_STEP;
        end else begin
            if (w[6:0] == `OPC_OP_IMM) begin
                b = {{20{w[31]}}, w[31:20]};
            end
            // Bit 30 selects SUB or SRA and is plain immediate elsewhere
            alt = w[30] && (w[6:0] == `OPC_OP || w[14:12] == 3'b101);
            res = alu_ref(w[14:12], alt, a, b);
            if (w[11:7] != 5'd0) begin
                x[w[11:7]] = res;
            end
            push_expected(pc, w[11:7] != 5'd0, w[11:7], res);
            pc = pc + `PC_STEP;
        end
    end
endtask

`endif

//--- dv/core_tb.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module core_tb;

    localparam int          CLK_PERIOD = 8;
    localparam int          PROG_WORDS = 64;
    localparam int          PROG_BYTES = PROG_WORDS * 4;
    localparam int          IDX_W      = $clog2(PROG_WORDS);
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;

    logic                   clk;
    logic                   rst_n;
    logic [`XLEN-1:0]       imem_addr;
    logic [`XLEN-1:0]       imem_data;
    logic                   retire_vld;
    logic [`XLEN-1:0]       retire_pc;
    logic                   retire_we;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic [`XLEN-1:0]       retire_data;

    logic [`XLEN-1:0] prog_mem [0:PROG_WORDS-1];
    logic [15:0]      lfsr;

    // Expected retirements in program order
    logic [`XLEN-1:0]       exp_pc_q[$];
    logic                   exp_we_q[$];
    logic [`REG_ADDR_W-1:0] exp_rd_q[$];
    logic [`XLEN-1:0]       exp_data_q[$];
    int                     ref_count;
    int                     retire_count = 0;

    // Queue head as seen by the assertions
    logic                   head_avail = 1'b0;
    logic [`XLEN-1:0]       head_pc    = '0;
    logic                   head_we    = 1'b0;
    logic [`REG_ADDR_W-1:0] head_rd    = '0;
    logic [`XLEN-1:0]       head_data  = '0;

    `include "core_ref_model.svh"

    riscv_core UUT (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .imem_data_i   (imem_data),
        .imem_addr_o   (imem_addr),
        .retire_vld_o  (retire_vld),
        .retire_pc_o   (retire_pc),
        .retire_we_o   (retire_we),
        .retire_rd_o   (retire_rd),
        .retire_data_o (retire_data)
    );

    // Past the program the fetch sees ADDI x0,x0,0
    assign imem_data = (imem_addr < PROG_BYTES) ? prog_mem[imem_addr[IDX_W+1:2]] : NOP_WORD;

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic load_head();
        head_avail = (exp_pc_q.size() > 0);
        if (head_avail) begin
            head_pc   = exp_pc_q[0];
            head_we   = exp_we_q[0];
            head_rd   = exp_rd_q[0];
            head_data = exp_data_q[0];
        end
    endtask

    initial begin
        rst_n = 1'b1;
        gen_program();
        run_model();
        load_head();
        #1;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    // Consume one expected entry per strobe
    always @(posedge clk) begin
        if (rst_n && retire_vld && retire_pc < PROG_BYTES) begin
            retire_count = retire_count + 1;
        end
        if (rst_n && retire_vld && head_avail) begin
            void'(exp_pc_q.pop_front());
            void'(exp_we_q.pop_front());
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
            load_head();
        end
    end

    a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !retire_vld)
        else abort_run("retire strobe while reset is asserted");

    a_first_pc: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_vld && retire_count == 0 |-> retire_pc == `RESET_PC
    ) else abort_run($sformatf("Fail at %0t: first retire_pc_o = %h, expected %h",
                               $time, $sampled(retire_pc), `RESET_PC));

    a_strobe_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_vld && retire_pc < PROG_BYTES |-> head_avail
    ) else abort_run("retire strobe inside the program with no retirement left to expect");

    a_retire_pc: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_vld && head_avail |-> retire_pc == head_pc
    ) else abort_run($sformatf("Fail at %0t: retire_pc_o = %h, expected %h",
                               $time, $sampled(retire_pc), $sampled(head_pc)));

    a_retire_we: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_vld && head_avail |-> retire_we == head_we
    ) else abort_run($sformatf("Fail at %0t: retire_we_o = %b, expected %b",
                               $time, $sampled(retire_we), $sampled(head_we)));

    a_retire_rd: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_vld && head_avail && head_we |-> retire_rd == head_rd
    ) else abort_run($sformatf("Fail at %0t: retire_rd_o = %0d, expected %0d",
                               $time, $sampled(retire_rd), $sampled(head_rd)));

    a_retire_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_vld && head_avail && head_we |-> retire_data == head_data
    ) else abort_run($sformatf("Fail at %0t: retire_data_o = %h, expected %h",
                               $time, $sampled(retire_data), $sampled(head_data)));

    // Run ends when the first PC past the program retires
    initial begin : end_check
        wait (rst_n);
        @(posedge clk);
        while (!(retire_vld && retire_pc >= PROG_BYTES)) begin
            @(posedge clk);
        end
        // Assertions of this edge resolve before the negedge
        @(negedge clk);
        if (exp_pc_q.size() == 0 && retire_count == ref_count) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("program end retired after %0d of %0d expected retirements",
                                retire_count, ref_count));
        end
    end

    initial begin : watchdog
        #((3 * PROG_WORDS + 20) * CLK_PERIOD);
        abort_run("timeout before the end of the program retired");
    end

endmodule

//--- flist.f
+incdir+logic
+incdir+dv
logic/core_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/retire_stage.sv
logic/riscv_core.sv
dv/core_tb.sv

//--- logic/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and PC width
`define XLEN       32
`define REG_ADDR_W 5
`define NUM_REGS   32

`define RESET_PC   32'h0000_0000
`define PC_STEP    32'd4

// Supported major opcodes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_BRANCH 7'b1100011

`endif

//--- logic/core_pkg.sv
package core_pkg;

    // Register-register view
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Branch immediate is scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG   = 2'b00,
        FWD_EXMEM = 2'b01,
        FWD_MEMWB = 2'b10
    } fwd_sel_e;

endpackage

//--- logic/decode_stage.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module decode_stage import core_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  instr_u                 ifid_instr_i,
    input  logic [`XLEN-1:0]       ifid_pc_i,
    input  logic                   ifid_vld_i,
    input  logic                   flush_i,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    output logic                   idex_vld_o,
    output logic [`XLEN-1:0]       idex_pc_o,
    output logic [`REG_ADDR_W-1:0] idex_rs1_o,
    output logic [`REG_ADDR_W-1:0] idex_rs2_o,
    output logic [`REG_ADDR_W-1:0] idex_rd_o,
    output logic [`XLEN-1:0]       idex_rs1_data_o,
    output logic [`XLEN-1:0]       idex_rs2_data_o,
    output logic [`XLEN-1:0]       idex_imm_o,
    output alu_op_e                idex_alu_op_o,
    output logic                   idex_use_imm_o,
    output logic                   idex_is_br_o,
    output logic [2:0]             idex_funct3_o,
    output logic                   idex_we_o
);
    logic             legal;
    logic             writes_rd;
    logic             use_imm;
    logic             is_br;
    logic             base_f7;
    logic             alt_f7;
    logic             sub_sel;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;

    assign rs1_addr_o = ifid_instr_i.r.rs1;
    assign rs2_addr_o = ifid_instr_i.r.rs2;

    assign base_f7 = (ifid_instr_i.r.funct7 == 7'b0000000);
    assign alt_f7  = (ifid_instr_i.r.funct7 == 7'b0100000);
    // ADDI has no alternate form, bit 30 is plain immediate there
    assign sub_sel = (ifid_instr_i.r.opcode == `OPC_OP) && alt_f7;

    always_comb begin
        legal     = 1'b0;
        writes_rd = 1'b0;
        use_imm   = 1'b0;
        is_br     = 1'b0;
        case (ifid_instr_i.r.opcode)
            `OPC_OP: begin
                writes_rd = 1'b1;
                legal     = base_f7 || (alt_f7 && (ifid_instr_i.r.funct3 == 3'b000 ||
                                                   ifid_instr_i.r.funct3 == 3'b101));
            end
            `OPC_OP_IMM: begin
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                case (ifid_instr_i.i.funct3)
                    3'b001:  legal = base_f7;
                    3'b101:  legal = base_f7 || alt_f7;
                    default: legal = 1'b1;
                endcase
            end
            `OPC_BRANCH: begin
                is_br = 1'b1;
                // BEQ, BNE, BLT, BGE only
                legal = !ifid_instr_i.b.funct3[1];
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (ifid_instr_i.r.funct3)
            3'b000:  alu_op = sub_sel ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = ifid_instr_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    // Sign-extended immediates
    assign imm_i = {{(`XLEN-12){ifid_instr_i.i.imm12[11]}}, ifid_instr_i.i.imm12};
    assign imm_b = {{(`XLEN-12){ifid_instr_i.b.imm12}}, ifid_instr_i.b.imm11,
                    ifid_instr_i.b.imm10_5, ifid_instr_i.b.imm4_1, 1'b0};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idex_vld_o      <= 1'b0;
            idex_we_o       <= 1'b0;
            idex_is_br_o    <= 1'b0;
            idex_use_imm_o  <= 1'b0;
            idex_alu_op_o   <= ALU_ADD;
            idex_funct3_o   <= '0;
            idex_pc_o       <= '0;
            idex_rs1_o      <= '0;
            idex_rs2_o      <= '0;
            idex_rd_o       <= '0;
            idex_rs1_data_o <= '0;
            idex_rs2_data_o <= '0;
            idex_imm_o      <= '0;
        end else begin
            // Illegal or flushed slots become bubbles, x0 writes dropped here
            idex_vld_o      <= ifid_vld_i && legal && !flush_i;
            idex_we_o       <= ifid_vld_i && legal && !flush_i && writes_rd &&
                               (ifid_instr_i.r.rd != '0);
            idex_is_br_o    <= is_br;
            idex_use_imm_o  <= use_imm;
            idex_alu_op_o   <= alu_op;
            idex_funct3_o   <= ifid_instr_i.r.funct3;
            idex_pc_o       <= ifid_pc_i;
            idex_rs1_o      <= ifid_instr_i.r.rs1;
            idex_rs2_o      <= ifid_instr_i.r.rs2;
            idex_rd_o       <= ifid_instr_i.r.rd;
            idex_rs1_data_o <= rs1_data_i;
            idex_rs2_data_o <= rs2_data_i;
            idex_imm_o      <= is_br ? imm_b : imm_i;
        end
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module execute_stage import core_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   idex_vld_i,
    input  logic [`XLEN-1:0]       idex_pc_i,
    input  logic [`REG_ADDR_W-1:0] idex_rs1_i,
    input  logic [`REG_ADDR_W-1:0] idex_rs2_i,
    input  logic [`REG_ADDR_W-1:0] idex_rd_i,
    input  logic [`XLEN-1:0]       idex_rs1_data_i,
    input  logic [`XLEN-1:0]       idex_rs2_data_i,
    input  logic [`XLEN-1:0]       idex_imm_i,
    input  alu_op_e                idex_alu_op_i,
    input  logic                   idex_use_imm_i,
    input  logic                   idex_is_br_i,
    input  logic [2:0]             idex_funct3_i,
    input  logic                   idex_we_i,
    input  logic                   memwb_we_i,
    input  logic [`REG_ADDR_W-1:0] memwb_rd_i,
    input  logic [`XLEN-1:0]       memwb_data_i,
    output logic                   redirect_o,
    output logic [`XLEN-1:0]       redirect_pc_o,
    output logic                   exmem_vld_o,
    output logic                   exmem_we_o,
    output logic [`REG_ADDR_W-1:0] exmem_rd_o,
    output logic [`XLEN-1:0]       exmem_data_o,
    output logic [`XLEN-1:0]       exmem_pc_o
);
    fwd_sel_e         rs1_sel;
    fwd_sel_e         rs2_sel;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic             eq;
    logic             lt_s;
    logic             lt_u;
    logic             taken;
    logic [$clog2(`XLEN)-1:0] shamt;

    // Younger producer in EX/MEM has priority
    function automatic fwd_sel_e pick_src(input logic [`REG_ADDR_W-1:0] rs,
                                          input logic exmem_we,
                                          input logic [`REG_ADDR_W-1:0] exmem_rd,
                                          input logic memwb_we,
                                          input logic [`REG_ADDR_W-1:0] memwb_rd);
        if (rs == '0) begin
            return FWD_REG;
        end
        if (exmem_we && (exmem_rd == rs)) begin
            return FWD_EXMEM;
        end
        if (memwb_we && (memwb_rd == rs)) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    assign rs1_sel = pick_src(idex_rs1_i, exmem_we_o, exmem_rd_o, memwb_we_i, memwb_rd_i);
    assign rs2_sel = pick_src(idex_rs2_i, exmem_we_o, exmem_rd_o, memwb_we_i, memwb_rd_i);

    assign rs1_val = (rs1_sel == FWD_EXMEM) ? exmem_data_o :
                     (rs1_sel == FWD_MEMWB) ? memwb_data_i : idex_rs1_data_i;
    assign rs2_val = (rs2_sel == FWD_EXMEM) ? exmem_data_o :
                     (rs2_sel == FWD_MEMWB) ? memwb_data_i : idex_rs2_data_i;

    assign op_b  = idex_use_imm_i ? idex_imm_i : rs2_val;
    assign shamt = op_b[$clog2(`XLEN)-1:0];

    // Shared by SLT/SLTU and the branch compare
    assign eq   = (rs1_val == op_b);
    assign lt_s = ($signed(rs1_val) < $signed(op_b));
    assign lt_u = (rs1_val < op_b);

    always_comb begin
        case (idex_alu_op_i)
            ALU_SUB:  alu_res = rs1_val - op_b;
            ALU_SLL:  alu_res = rs1_val << shamt;
            ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  alu_res = rs1_val ^ op_b;
            ALU_SRL:  alu_res = rs1_val >> shamt;
            ALU_SRA:  alu_res = $signed(rs1_val) >>> shamt;
            ALU_OR:   alu_res = rs1_val | op_b;
            ALU_AND:  alu_res = rs1_val & op_b;
            default:  alu_res = rs1_val + op_b;
        endcase
    end

    // funct3[2] picks LT over EQ and funct3[0] inverts
    assign taken = (idex_funct3_i[2] ? lt_s : eq) ^ idex_funct3_i[0];

    assign redirect_o    = idex_vld_i && idex_is_br_i && taken;
    assign redirect_pc_o = idex_pc_i + idex_imm_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            exmem_vld_o  <= 1'b0;
            exmem_we_o   <= 1'b0;
            exmem_rd_o   <= '0;
            exmem_data_o <= '0;
            exmem_pc_o   <= '0;
        end else begin
            exmem_vld_o  <= idex_vld_i;
            exmem_we_o   <= idex_we_i;
            exmem_rd_o   <= idex_rd_i;
            exmem_data_o <= alu_res;
            exmem_pc_o   <= idex_pc_i;
        end
    end

    a_fwd_exmem_writes: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (rs1_sel == FWD_EXMEM || rs2_sel == FWD_EXMEM) |-> exmem_we_o && exmem_vld_o
    );

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module fetch_stage import core_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  instr_u           instr_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] redirect_pc_i,
    output logic [`XLEN-1:0] pc_o,
    output instr_u           ifid_instr_o,
    output logic [`XLEN-1:0] ifid_pc_o,
    output logic             ifid_vld_o
);
    logic [`XLEN-1:0] pc_next;

    // Static not-taken, execute overrides on a taken branch
    assign pc_next = redirect_i ? redirect_pc_i : pc_o + `PC_STEP;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_o <= `RESET_PC;
        end else begin
            pc_o <= pc_next;
        end
    end

    // IF/ID, wrong-path word dropped on redirect
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ifid_instr_o <= '0;
            ifid_pc_o    <= '0;
            ifid_vld_o   <= 1'b0;
        end else begin
            ifid_instr_o <= instr_i;
            ifid_pc_o    <= pc_o;
            ifid_vld_o   <= !redirect_i;
        end
    end

    a_redirect_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        redirect_i |-> (redirect_pc_i[1:0] == 2'b00)
    );

endmodule

//--- logic/reg_file.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module reg_file (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o
);
    // No storage for x0
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    // Write data of this cycle wins over the stored value
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && (waddr_i == addr)) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

//--- logic/retire_stage.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module retire_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   exmem_vld_i,
    input  logic                   exmem_we_i,
    input  logic [`REG_ADDR_W-1:0] exmem_rd_i,
    input  logic [`XLEN-1:0]       exmem_data_i,
    input  logic [`XLEN-1:0]       exmem_pc_i,
    output logic                   memwb_we_o,
    output logic [`REG_ADDR_W-1:0] memwb_rd_o,
    output logic [`XLEN-1:0]       memwb_data_o,
    output logic                   retire_vld_o,
    output logic [`XLEN-1:0]       retire_pc_o
);

    // MEM/WB, the memory stage itself is empty
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            retire_vld_o <= 1'b0;
            memwb_we_o   <= 1'b0;
            memwb_rd_o   <= '0;
            memwb_data_o <= '0;
            retire_pc_o  <= '0;
        end else begin
            retire_vld_o <= exmem_vld_i;
            memwb_we_o   <= exmem_we_i;
            memwb_rd_o   <= exmem_rd_i;
            memwb_data_o <= exmem_data_i;
            retire_pc_o  <= exmem_pc_i;
        end
    end

    a_wb_rd_nonzero: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        memwb_we_o |-> (memwb_rd_o != '0) && retire_vld_o
    );

endmodule

//--- logic/riscv_core.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module riscv_core import core_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [`XLEN-1:0]       imem_data_i,
    output logic [`XLEN-1:0]       imem_addr_o,
    output logic                   retire_vld_o,
    output logic [`XLEN-1:0]       retire_pc_o,
    output logic                   retire_we_o,
    output logic [`REG_ADDR_W-1:0] retire_rd_o,
    output logic [`XLEN-1:0]       retire_data_o
);
    // IF/ID
    instr_u                 ifid_instr;
    logic [`XLEN-1:0]       ifid_pc;
    logic                   ifid_vld;

    // Register file read side
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    // ID/EX
    logic                   idex_vld;
    logic [`XLEN-1:0]       idex_pc;
    logic [`REG_ADDR_W-1:0] idex_rs1;
    logic [`REG_ADDR_W-1:0] idex_rs2;
    logic [`REG_ADDR_W-1:0] idex_rd;
    logic [`XLEN-1:0]       idex_rs1_data;
    logic [`XLEN-1:0]       idex_rs2_data;
    logic [`XLEN-1:0]       idex_imm;
    alu_op_e                idex_alu_op;
    logic                   idex_use_imm;
    logic                   idex_is_br;
    logic [2:0]             idex_funct3;
    logic                   idex_we;

    // Branch redirect from execute
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;

    // EX/MEM
    logic                   exmem_vld;
    logic                   exmem_we;
    logic [`REG_ADDR_W-1:0] exmem_rd;
    logic [`XLEN-1:0]       exmem_data;
    logic [`XLEN-1:0]       exmem_pc;

    // MEM/WB write-back port
    logic                   memwb_we;
    logic [`REG_ADDR_W-1:0] memwb_rd;
    logic [`XLEN-1:0]       memwb_data;

    fetch_stage u_fetch (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .instr_i       (imem_data_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .pc_o          (imem_addr_o),
        .ifid_instr_o  (ifid_instr),
        .ifid_pc_o     (ifid_pc),
        .ifid_vld_o    (ifid_vld)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .we_i     (memwb_we),
        .waddr_i  (memwb_rd),
        .wdata_i  (memwb_data),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    decode_stage u_decode (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ifid_instr_i    (ifid_instr),
        .ifid_pc_i       (ifid_pc),
        .ifid_vld_i      (ifid_vld),
        .flush_i         (redirect),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .idex_vld_o      (idex_vld),
        .idex_pc_o       (idex_pc),
        .idex_rs1_o      (idex_rs1),
        .idex_rs2_o      (idex_rs2),
        .idex_rd_o       (idex_rd),
        .idex_rs1_data_o (idex_rs1_data),
        .idex_rs2_data_o (idex_rs2_data),
        .idex_imm_o      (idex_imm),
        .idex_alu_op_o   (idex_alu_op),
        .idex_use_imm_o  (idex_use_imm),
        .idex_is_br_o    (idex_is_br),
        .idex_funct3_o   (idex_funct3),
        .idex_we_o       (idex_we)
    );

    execute_stage u_execute (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .idex_vld_i      (idex_vld),
        .idex_pc_i       (idex_pc),
        .idex_rs1_i      (idex_rs1),
        .idex_rs2_i      (idex_rs2),
        .idex_rd_i       (idex_rd),
        .idex_rs1_data_i (idex_rs1_data),
        .idex_rs2_data_i (idex_rs2_data),
        .idex_imm_i      (idex_imm),
        .idex_alu_op_i   (idex_alu_op),
        .idex_use_imm_i  (idex_use_imm),
        .idex_is_br_i    (idex_is_br),
        .idex_funct3_i   (idex_funct3),
        .idex_we_i       (idex_we),
        .memwb_we_i      (memwb_we),
        .memwb_rd_i      (memwb_rd),
        .memwb_data_i    (memwb_data),
        .redirect_o      (redirect),
        .redirect_pc_o   (redirect_pc),
        .exmem_vld_o     (exmem_vld),
        .exmem_we_o      (exmem_we),
        .exmem_rd_o      (exmem_rd),
        .exmem_data_o    (exmem_data),
        .exmem_pc_o      (exmem_pc)
    );

    retire_stage u_retire (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .exmem_vld_i  (exmem_vld),
        .exmem_we_i   (exmem_we),
        .exmem_rd_i   (exmem_rd),
        .exmem_data_i (exmem_data),
        .exmem_pc_i   (exmem_pc),
        .memwb_we_o   (memwb_we),
        .memwb_rd_o   (memwb_rd),
        .memwb_data_o (memwb_data),
        .retire_vld_o (retire_vld_o),
        .retire_pc_o  (retire_pc_o)
    );

    // Retire port mirrors the write-back port
    assign retire_we_o   = memwb_we;
    assign retire_rd_o   = memwb_rd;
    assign retire_data_o = memwb_data;

endmodule
